/* Bender.yml */
package:
  name: prefetch_queue

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pf_pkg.sv
      - hw/fetch_fifo.sv
      - hw/fetch_pc_gen.sv
      - hw/fetch_rsp_join.sv
      - hw/prefetch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/mem_model.sv
      - bench/prefetch_tb.sv

/* bench/mem_model.sv */
`timescale 1ns/1ps
`include "pf_macros.svh"

// In-order instruction memory, 1 to 4 cycles from request to answer
module mem_model
   import pf_pkg::*;
#(
   parameter logic [`PF_XLEN-1:0] KEY = 32'hA5A5_A5A5 // Instruction word is address ^ KEY
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                mem_req,
   input  logic [`PF_XLEN-1:0] mem_req_addr,
   input  logic [1:0]          lat_sel,       // Extra delay for a request seen now
   output logic                mem_rsp,
   output mem_rsp_t            mem_rsp_data
);

   logic [`PF_XLEN-1:0] addr_q [$];  // Pending addresses, oldest first
   int unsigned         due_q  [$];  // Edge index that answers each one
   int unsigned         now      = 0;
   int unsigned         last_due = 0; // Keeps answers in order, one per cycle

   initial begin
      mem_rsp      = 1'b0;
      mem_rsp_data = '0;
   end

   always @(posedge clk) begin
      int unsigned due;
      if (rst) begin
         addr_q.delete();
         due_q.delete();
         now      = 0;
         last_due = 0;
         mem_rsp <= 1'b0;
         mem_rsp_data <= '0;
      end else begin
         now = now + 1;
         if (mem_req) begin
            due = now + lat_sel;                  // lat_sel 0 answers next cycle
            if (due <= last_due) begin
               due = last_due + 1;                // Never overtake an older request
            end
            addr_q.push_back(mem_req_addr);
            due_q.push_back(due);
            last_due = due;
         end
         if ((due_q.size() != 0) && (due_q[0] <= now)) begin
            mem_rsp           <= 1'b1;
            mem_rsp_data.data <= addr_q[0] ^ KEY;
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
         end else begin
            mem_rsp <= 1'b0;
         end
      end
   end

endmodule

/* bench/prefetch_tb.sv */
`timescale 1ns/1ps
`include "pf_macros.svh"

module prefetch_tb
   import pf_pkg::*;
();

   localparam logic [`PF_XLEN-1:0] INSTR_KEY = 32'hA5A5_A5A5;
   // Cycle budget of each test
   localparam int T1_CYC = 20;
   localparam int T2_CYC = 120;
   localparam int T3_CYC = 300;
   localparam int T4_CYC = 100;
   localparam int T5_CYC = 300;
   // Sum of the budgets plus slack
   localparam int TIMEOUT_CYC = T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 200;

   logic                clk = 1'b0;
   logic                rst = 1'b1;
   logic                redirect = 1'b0;
   redirect_t           redirect_data = '0;
   logic                deq_en = 1'b0;
   logic                deq;
   logic                mem_req;
   logic [`PF_XLEN-1:0] mem_req_addr;
   logic                mem_rsp;
   mem_rsp_t            mem_rsp_data;
   logic                fetch_valid;
   fetch_pkt_t          fetch_pkt;
   logic [1:0]          lat_sel = 2'd0;
   logic [15:0]         lfsr = 16'd34;
   logic [7:0]          spare = 8'd0;   // Random byte for redirect gaps and targets
   logic [1:0]          deq_mode = 2'd0; // 0 hold, 1 always, 2 random
   logic                redirect_seen = 1'b0;
   logic [`PF_XLEN-1:0] exp_pc = `PF_RESET_PC; // Next pc decode should see
   int                  req_cnt = 0;
   int                  pop_cnt = 0;
   int                  coinc_cnt = 0;  // Redirects landing on a response
   int                  err_cnt = 0;
   int                  fail_tests = 0;
   int                  cycle = 0;
   int                  k;
   int                  mark;

   assign deq = deq_en & fetch_valid;   // Decode only pops a valid head

   prefetch_top uut (
      .clk(clk), .rst(rst), .mem_req(mem_req), .mem_req_addr(mem_req_addr),
      .mem_rsp(mem_rsp), .mem_rsp_data(mem_rsp_data), .redirect(redirect),
      .redirect_data(redirect_data), .fetch_valid(fetch_valid),
      .fetch_pkt(fetch_pkt), .deq(deq)
   );

   mem_model #(.KEY(INSTR_KEY)) u_mem (
      .clk(clk), .rst(rst), .mem_req(mem_req), .mem_req_addr(mem_req_addr),
      .lat_sel(lat_sel), .mem_rsp(mem_rsp), .mem_rsp_data(mem_rsp_data)
   );

   always #20 clk = ~clk;

   // Fibonacci taps 16,14,13,11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   always @(posedge clk) begin
      logic [15:0] s;
      logic [10:0] bits;
      s = lfsr;
      for (int i = 0; i < 11; i++) begin
         s = lfsr_step(s);                // One step per bit
         bits[i] = s[0];
      end
      lfsr    <= s;
      lat_sel <= bits[1:0];
      spare   <= bits[10:3];
      deq_en  <= (deq_mode == 2'd1) || ((deq_mode == 2'd2) && bits[2]);
   end

   // Scoreboard and traffic counters
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYC) begin
         $display("Run stopped, no completion within %0d cycles", TIMEOUT_CYC);
         $display("TB FAILED");
         $finish;
      end else if (rst) begin
         exp_pc  <= `PF_RESET_PC;
         req_cnt <= 0;
         pop_cnt <= 0;
      end else begin
         if (redirect) begin
            exp_pc <= redirect_data.target; // New path starts at the target
         end else if (deq) begin
            exp_pc <= exp_pc + 32'd4;
         end
         if (mem_req) req_cnt <= req_cnt + 1;
         if (deq) pop_cnt <= pop_cnt + 1;
         if (redirect && mem_rsp) coinc_cnt <= coinc_cnt + 1;
      end
   end

   a_reset_out : assert property (@(posedge clk) $fell(rst) |-> (!fetch_valid && !mem_req))
      else begin
         $display("Error: mem_req expected 0 got %h, fetch_valid expected 0 got %h",
                  $sampled(mem_req), $sampled(fetch_valid));
         err_cnt++;
      end

   a_first_addr : assert property (@(posedge clk)
      $fell(rst) |=> (mem_req && (mem_req_addr == `PF_RESET_PC)))
      else begin
         $display("Error: mem_req_addr expected %h got %h (mem_req %h)",
                  `PF_RESET_PC, $sampled(mem_req_addr), $sampled(mem_req));
         err_cnt++;
      end

   a_pkt_pc : assert property (@(posedge clk) disable iff (rst)
      deq |-> (fetch_pkt.pc == exp_pc))
      else begin
         $display("Error: fetch_pkt.pc expected %h got %h", $sampled(exp_pc),
                  $sampled(fetch_pkt.pc));
         err_cnt++;
      end

   a_pkt_instr : assert property (@(posedge clk) disable iff (rst)
      deq |-> (fetch_pkt.instr == (fetch_pkt.pc ^ INSTR_KEY)))
      else begin
         $display("Error: fetch_pkt.instr expected %h got %h",
                  $sampled(fetch_pkt.pc) ^ INSTR_KEY, $sampled(fetch_pkt.instr));
         err_cnt++;
      end

   // Only exact while every issued request ends up popped
   a_in_flight : assert property (@(posedge clk) disable iff (rst || redirect_seen)
      (req_cnt - pop_cnt) <= `PF_DEPTH)
      else begin
         $display("Error: req_cnt - pop_cnt expected at most %h got %h", `PF_DEPTH,
                  $sampled(req_cnt - pop_cnt));
         err_cnt++;
      end

   task automatic wait_pops(input int n);
      int goal;
      goal = pop_cnt + n;
      while (pop_cnt < goal) @(posedge clk);
   endtask

   task automatic send_redirect(input logic [`PF_XLEN-1:0] target);
      redirect             <= 1'b1;
      redirect_data.target <= target;
      @(posedge clk);
      redirect <= 1'b0;
   endtask

   // One edge of slack so checks at the last edge are counted
   task automatic finish_test(input string name, input int errs_before);
      @(posedge clk);
      if (err_cnt == errs_before) begin
         $display("Test %s: ok", name);
      end else begin
         $display("Test %s: %0d errors", name, err_cnt - errs_before);
         fail_tests++;
      end
   endtask

   initial begin
      repeat (8) @(posedge clk);
      mark = err_cnt;
      rst <= 1'b0;
      while (!mem_req) @(posedge clk);     // First request after reset
      finish_test("reset state", mark);

      mark = err_cnt;
      deq_mode <= 2'd1;
      wait_pops(40);
      finish_test("sequential order", mark);

      mark = err_cnt;
      deq_mode <= 2'd2;
      wait_pops(60);
      finish_test("variable latency", mark);

      mark = err_cnt;
      deq_mode <= 2'd0;
      while ((req_cnt - pop_cnt) != `PF_DEPTH) @(posedge clk);
      repeat (12) @(posedge clk);          // Issue must stay stalled
      deq_mode <= 2'd1;
      wait_pops(`PF_DEPTH + 4);
      finish_test("back-pressure", mark);

      mark = err_cnt;
      redirect_seen <= 1'b1;
      deq_mode <= 2'd2;
      k = 0;
      while ((k < 12) || (coinc_cnt < 3)) begin
         repeat (spare[1:0]) @(posedge clk); // Gap 0 gives back-to-back redirects
         send_redirect(32'h4000_0000 + (k << 12) + {spare[7:2], 2'b00});
         k++;
      end
      deq_mode <= 2'd1;
      wait_pops(20);
      $display("Redirects sent %0d, on a response %0d", k, coinc_cnt);
      finish_test("redirect", mark);

      $display("Summary: 5 tests, %0d failed, %0d errors", fail_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+hw
hw/pf_pkg.sv
hw/fetch_fifo.sv
hw/fetch_pc_gen.sv
hw/fetch_rsp_join.sv
hw/prefetch_top.sv
bench/mem_model.sv
bench/prefetch_tb.sv

/* hw/fetch_fifo.sv */
`timescale 1ns/1ps
`include "pf_macros.svh"

// Circular buffer queue, payload chosen by the instantiating block
module fetch_fifo #(
   parameter type T     = logic [`PF_XLEN-1:0], // Payload type
   parameter int  DEPTH = `PF_DEPTH             // Number of entries
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 flush,     // Drops every entry at the edge
   input  logic                 push,
   input  T                     push_data,
   output logic                 full,
   input  logic                 pop,
   output T                     pop_data,  // Head entry, valid while not empty
   output logic                 empty,
   output logic [`PF_CNT_W-1:0] count     // Entries held
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);      // Wrap point
   localparam logic [`PF_CNT_W-1:0] FULL_CNT = `PF_CNT_W'(DEPTH);

   T                     data_q [DEPTH]; // Entry storage
   logic [PTR_W-1:0]     wr_ptr;         // Next slot to write
   logic [PTR_W-1:0]     rd_ptr;         // Current head slot
   logic [`PF_CNT_W-1:0] cnt;            // Data counter
   logic                 wr_en;          // Accepted push
   logic                 rd_en;          // Accepted pop

   assign empty    = (cnt == '0);
   assign full     = (cnt == FULL_CNT);
   assign count    = cnt;
   assign pop_data = data_q[rd_ptr];     // Combinational head

   assign rd_en = pop & ~empty;          // Pop on empty ignored
   assign wr_en = push & (~full | rd_en); // Same-cycle pop frees the slot

   // Storage write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_q[wr_ptr] <= push_data;
      end
   end

   // Pointers and counter
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (wr_en) begin
            if (wr_ptr == LAST_PTR) begin
               wr_ptr <= '0;             // Wrap at depth
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end

         if (rd_en) begin
            if (rd_ptr == LAST_PTR) begin
               rd_ptr <= '0;             // Wrap at depth
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end

         if (wr_en && !rd_en) begin
            cnt <= cnt + 1'b1;           // Write only
         end else if (!wr_en && rd_en) begin
            cnt <= cnt - 1'b1;           // Read only
         end
      end
   end

   // The producer must respect its credit and never lose a push to a full queue
   a_no_overflow : assert property (
      @(posedge clk) disable iff (rst)
      (push && full && !flush) |-> pop
   ) else $error("fetch_fifo push while full without pop");

endmodule

/* hw/fetch_pc_gen.sv */
`timescale 1ns/1ps
`include "pf_macros.svh"

// Sequential fetch address generator with credit-based flow control
module fetch_pc_gen
   import pf_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 redirect,      // Branch or jump strobe from core
   input  redirect_t            redirect_data,
   input  logic [`PF_CNT_W-1:0] pkt_count,     // Packets waiting for decode
   input  logic                 rsp_retire,    // One response joined or killed
   output logic                 mem_req,       // Registered request strobe
   output logic [`PF_XLEN-1:0]  mem_req_addr
);

   localparam int CREDIT_W = `PF_CNT_W + 1;
   localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`PF_DEPTH);

   logic [`PF_XLEN-1:0]  next_pc;     // Address of the next request
   logic [`PF_XLEN-1:0]  issue_pc;    // Target wins over the sequential address
   logic [`PF_CNT_W-1:0] outstanding; // Requests not yet answered
   logic [CREDIT_W-1:0]  credit_used; // Outstanding plus queued packets
   logic                 issue;       // Request decided this cycle

   assign issue_pc    = redirect ? redirect_data.target : next_pc;
   assign credit_used = {1'b0, outstanding} + {1'b0, pkt_count};
   assign issue       = (credit_used < CREDIT_MAX); // A free packet slot is reserved

   // Request strobe, next address and credit counter
   always_ff @(posedge clk) begin
      if (rst) begin
         mem_req     <= 1'b0;
         next_pc     <= `PF_RESET_PC;
         outstanding <= '0;
      end else begin
         mem_req <= issue;
         if (issue) begin
            next_pc <= issue_pc + `PF_XLEN'(4); // Step one word
         end else begin
            next_pc <= issue_pc;                // Hold, or latch redirect target
         end

         if (issue && !rsp_retire) begin
            outstanding <= outstanding + 1'b1;
         end else if (!issue && rsp_retire) begin
            outstanding <= outstanding - 1'b1;
         end
      end
   end

   // Request address register
   always_ff @(posedge clk) begin
      if (issue) begin
         mem_req_addr <= issue_pc;
      end
   end

   // Credit bound across this block and the packet queue
   a_credit_bound : assert property (
      @(posedge clk) disable iff (rst)
      credit_used <= CREDIT_MAX
   ) else $error("fetch_pc_gen outstanding plus queued packets above depth");

   // Every retire must match a request issued earlier
   a_retire_owned : assert property (
      @(posedge clk) disable iff (rst)
      rsp_retire |-> (outstanding != '0)
   ) else $error("fetch_pc_gen retire with no outstanding request");

endmodule

/* hw/fetch_rsp_join.sv */
`timescale 1ns/1ps
`include "pf_macros.svh"

// Matches in-order memory responses with their request addresses
module fetch_rsp_join
   import pf_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                redirect,     // Discards every older request
   input  logic                mem_req,      // Request leaving this cycle
   input  logic [`PF_XLEN-1:0] mem_req_addr,
   input  logic                mem_rsp,
   input  mem_rsp_t            mem_rsp_data,
   output logic                rsp_retire,   // Frees one credit in the generator
   output logic                pkt_push,     // Write strobe into packet queue
   output fetch_pkt_t          pkt_data
);

   logic [`PF_XLEN-1:0]  req_head;  // Address of the oldest live request
   logic                 req_empty;
   logic [`PF_CNT_W-1:0] req_count; // Live requests awaiting data
   logic [`PF_CNT_W-1:0] kill_cnt;  // Responses still owed to a dead path
   logic [`PF_CNT_W:0]   kill_sum;  // Kill count after a redirect
   logic                 rsp_kill;  // Response dropped
   logic                 rsp_join;  // Response paired with its address

   fetch_fifo #(
      .T     (logic [`PF_XLEN-1:0]),
      .DEPTH (`PF_DEPTH)
   ) u_req_fifo (
      .clk       (clk),
      .rst       (rst),
      .flush     (redirect),
      .push      (mem_req),
      .push_data (mem_req_addr),
      .full      (),              // Bounded by the credit rule
      .pop       (rsp_join),
      .pop_data  (req_head),
      .empty     (req_empty),
      .count     (req_count)
   );

   assign rsp_kill   = mem_rsp & (kill_cnt != '0);  // Dead responses drain first
   assign rsp_join   = mem_rsp & (kill_cnt == '0);
   assign rsp_retire = rsp_kill | rsp_join;
   assign pkt_push   = rsp_join & ~redirect;        // Same-cycle response is stale

   assign pkt_data.pc    = req_head;
   assign pkt_data.instr = mem_rsp_data.data;

   // Dead requests include the one on the bus, less a response taken now
   assign kill_sum = {1'b0, kill_cnt} + {1'b0, req_count}
                   + {{`PF_CNT_W{1'b0}}, mem_req} - {{`PF_CNT_W{1'b0}}, mem_rsp};

   always_ff @(posedge clk) begin
      if (rst) begin
         kill_cnt <= '0;
      end else if (redirect) begin
         kill_cnt <= kill_sum[`PF_CNT_W-1:0];   // Never above depth
      end else if (rsp_kill) begin
         kill_cnt <= kill_cnt - 1'b1;
      end
   end

   // Memory answers only requests this block has recorded
   a_rsp_expected : assert property (
      @(posedge clk) disable iff (rst)
      mem_rsp |-> (!req_empty || (kill_cnt != '0))
   ) else $error("fetch_rsp_join response with nothing outstanding");

endmodule

/* hw/pf_macros.svh */
`ifndef PF_MACROS_SVH
`define PF_MACROS_SVH

// Entries per queue, also the total credit budget of the prefetcher
`define PF_DEPTH 8

// Address and instruction word width
`define PF_XLEN 32

// First fetch address after reset
`define PF_RESET_PC 32'h8000_0000

// Occupancy and credit counters, must hold the value PF_DEPTH
`define PF_CNT_W 4

`endif

/* hw/pf_pkg.sv */
`include "pf_macros.svh"

package pf_pkg;

   // Packet queue entry handed to decode
   typedef struct packed {
      logic [`PF_XLEN-1:0] pc;     // Address the word was fetched from
      logic [`PF_XLEN-1:0] instr;  // Raw instruction word
   } fetch_pkt_t;

   // In-order instruction memory answer
   typedef struct packed {
      logic [`PF_XLEN-1:0] data;   // Fetched word
   } mem_rsp_t;

   // Core redirect payload sampled with the redirect strobe
   typedef struct packed {
      logic [`PF_XLEN-1:0] target; // Word-aligned new fetch address
   } redirect_t;

endpackage

/* hw/prefetch_top.sv */
`timescale 1ns/1ps
`include "pf_macros.svh"

// Instruction prefetch queue between instruction memory and decode
module prefetch_top
   import pf_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   output logic                mem_req,       // Memory accepts every strobe
   output logic [`PF_XLEN-1:0] mem_req_addr,
   input  logic                mem_rsp,       // In-order answers
   input  mem_rsp_t            mem_rsp_data,
   input  logic                redirect,      // Flush and restart at target
   input  redirect_t           redirect_data,
   output logic                fetch_valid,   // Packet waiting at the head
   output fetch_pkt_t          fetch_pkt,
   input  logic                deq            // Pop strobe from decode
);

   logic                 rsp_retire;
   logic                 pkt_push;
   fetch_pkt_t           pkt_data;
   logic                 pkt_empty;
   logic [`PF_CNT_W-1:0] pkt_count;

   fetch_pc_gen u_pc_gen (
      .clk           (clk),
      .rst           (rst),
      .redirect      (redirect),
      .redirect_data (redirect_data),
      .pkt_count     (pkt_count),
      .rsp_retire    (rsp_retire),
      .mem_req       (mem_req),
      .mem_req_addr  (mem_req_addr)
   );

   fetch_rsp_join u_rsp_join (
      .clk          (clk),
      .rst          (rst),
      .redirect     (redirect),
      .mem_req      (mem_req),
      .mem_req_addr (mem_req_addr),
      .mem_rsp      (mem_rsp),
      .mem_rsp_data (mem_rsp_data),
      .rsp_retire   (rsp_retire),
      .pkt_push     (pkt_push),
      .pkt_data     (pkt_data)
   );

   fetch_fifo #(
      .T     (fetch_pkt_t),
      .DEPTH (`PF_DEPTH)
   ) u_pkt_fifo (
      .clk       (clk),
      .rst       (rst),
      .flush     (redirect),      // Queued packets belong to the old path
      .push      (pkt_push),
      .push_data (pkt_data),
      .full      (),              // Credit keeps a slot free
      .pop       (deq),
      .pop_data  (fetch_pkt),
      .empty     (pkt_empty),
      .count     (pkt_count)
   );

   assign fetch_valid = ~pkt_empty;

endmodule
